//--- Makefile
# Verilator flow for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RTL_SRCS  ?= hdl/dcache_pkg.sv hdl/dcache_way.sv hdl/dcache_hit_sel.sv \
             hdl/dcache_ctrl.sv hdl/dcache.sv
SRCS      := $(wildcard hdl/*.sv dv/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# pass or fail comes from the log, not from the simulator's exit code
run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/dcache_tb_tasks.svh
task automatic check_word(input string name, input word_t got, input word_t exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp)
   begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
   end
endtask

task automatic check_count(input string name, input int got, input int exp);
   checks++;
   if (got != exp)
   begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
   end
endtask

// byte address from tag, set and word in block
function automatic word_t make_addr(input int tag, input int idx, input int blk);
   return (word_t'(tag) << (IDX_W + BLK_W + BYTE_W)) |
          (word_t'(idx) << (BLK_W + BYTE_W)) |
          (word_t'(blk) << BYTE_W);
endfunction

// holds the request until dhit and counts the cycles spent waiting
task automatic run_access(input logic is_write, input word_t addr, input word_t data,
                          output word_t load, output int waited);
   dp_req_t r;
   r       = '0;
   r.ren   = !is_write;
   r.wen   = is_write;
   r.addr  = addr_t'(addr);
   r.store = data;
   @(posedge CLK);
   req    <= r;
   waited = 0;
   @(negedge CLK);
   while (!rsp.dhit)
   begin
      waited++;
      @(negedge CLK);
   end
   load = rsp.load;
   @(posedge CLK);
   req <= '0;
   @(negedge CLK);   // lets the memory model count the last word
endtask

task automatic read_and_check(input word_t addr, input logic exp_hit);
   word_t load;
   int    waited;
   run_access(1'b0, addr, '0, load, waited);
   check_word($sformatf("rsp.load @%h", addr), load, expected_word(addr));
   check_flag($sformatf("rsp.dhit in request cycle @%h", addr), waited == 0, exp_hit);
endtask

task automatic write_and_check(input word_t addr, input word_t data, input logic exp_hit);
   word_t load;
   int    waited;
   run_access(1'b1, addr, data, load, waited);
   shadow[addr] = data;
   check_flag($sformatf("rsp.dhit in request cycle @%h", addr), waited == 0, exp_hit);
endtask

task automatic read_miss_then_hit();
   int r0;
   int w0;
   r0 = mem_reads;
   w0 = mem_writes;
   read_and_check(make_addr(32'h10, 1, 0), 1'b0);
   check_count("mem reads on miss", mem_reads - r0, 2);
   r0 = mem_reads;
   read_and_check(make_addr(32'h10, 1, 1), 1'b1);   // other word of the same block
   check_count("mem reads on hit", mem_reads - r0, 0);
   check_count("mem writes", mem_writes - w0, 0);
endtask

task automatic write_hit_then_read();
   int r0;
   int w0;
   r0 = mem_reads;
   w0 = mem_writes;
   write_and_check(make_addr(32'h10, 1, 1), 32'hDEAD_BEEF, 1'b1);
   read_and_check(make_addr(32'h10, 1, 1), 1'b1);
   check_count("mem writes on write hit", mem_writes - w0, 0);
   check_count("mem reads on write hit", mem_reads - r0, 0);
endtask

task automatic dirty_eviction();
   word_t a0;
   word_t a1;
   int    r0;
   int    w0;
   a0 = make_addr(32'h20, 2, 0);
   a1 = make_addr(32'h20, 2, 1);
   read_and_check(a0, 1'b0);
   write_and_check(a0, 32'hCAFE_0020, 1'b1);
   read_and_check(make_addr(32'h21, 2, 0), 1'b0);
   r0 = mem_reads;
   w0 = mem_writes;
   read_and_check(make_addr(32'h22, 2, 0), 1'b0);   // evicts the dirty block
   check_count("write-back words", mem_writes - w0, 2);
   check_count("fill words", mem_reads - r0, 2);
   check_word($sformatf("memory @%h", a0), model_word(a0), shadow[a0]);
   check_word($sformatf("memory @%h", a1), model_word(a1), fill_word(a1));
endtask

task automatic lru_order();
   int r0;
   read_and_check(make_addr(32'h30, 3, 0), 1'b0);
   read_and_check(make_addr(32'h31, 3, 0), 1'b0);
   read_and_check(make_addr(32'h30, 3, 0), 1'b1);   // B is now least recent
   r0 = mem_reads;
   read_and_check(make_addr(32'h32, 3, 0), 1'b0);
   check_count("fill words for C", mem_reads - r0, 2);
   r0 = mem_reads;
   read_and_check(make_addr(32'h30, 3, 1), 1'b1);
   check_count("mem reads for A", mem_reads - r0, 0);
   read_and_check(make_addr(32'h31, 3, 0), 1'b0);
   check_count("fill words for B", mem_reads - r0, 2);
endtask

task automatic flush_on_halt();
   int r0;
   int w0;
   write_and_check(make_addr(32'h40, 4, 0), 32'h1111_0040, 1'b0);
   write_and_check(make_addr(32'h41, 4, 1), 32'h2222_0041, 1'b0);
   write_and_check(make_addr(32'h41, 4, 0), 32'h3333_0041, 1'b1);
   write_and_check(make_addr(32'h50, 5, 1), 32'h4444_0050, 1'b0);
   r0 = mem_reads;
   w0 = mem_writes;
   @(posedge CLK);
   halt <= 1'b1;
   @(negedge CLK);
   while (!flushed)
   begin
      @(negedge CLK);
   end
   // dirty blocks are tag 10 in set 1, tags 40 and 41 in set 4 and tag 50 in set 5
   check_count("flush write words", mem_writes - w0, 2 * 4);
   check_count("flush read words", mem_reads - r0, 0);
   foreach (shadow[a])
   begin
      check_word($sformatf("memory @%h", a), model_word(a), shadow[a]);
   end
   repeat (3) @(negedge CLK);
   check_flag("flushed", flushed, 1'b1);
endtask

//--- dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
   import dcache_pkg::*;
();

   // about 20 accesses of up to 4 words at 5 cycles each plus the flush scan
   localparam int MAX_CYCLES = 3000;

   logic     CLK = 1'b0;
   logic     nRST;
   dp_req_t  req;
   logic     halt;
   dp_rsp_t  rsp;
   logic     flushed;
   mem_req_t mem;
   logic     mem_wait;
   word_t    mem_load;

   int    seed;
   int    wait_left;    // extra wait cycles for the current memory word
   int    mem_reads;
   int    mem_writes;
   int    cycles;
   int    checks;
   int    errors;
   word_t mem_model [word_t];   // words written by the cache
   word_t shadow [word_t];      // values stored by the core

   always #4 CLK = ~CLK;

   dcache uut (
      .CLK      (CLK),
      .nRST     (nRST),
      .req      (req),
      .halt     (halt),
      .rsp      (rsp),
      .flushed  (flushed),
      .mem      (mem),
      .mem_wait (mem_wait),
      .mem_load (mem_load)
   );

   // initial memory contents from a rotated and scrambled address
   function automatic word_t fill_word(input word_t a);
      return {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
   endfunction

   function automatic word_t model_word(input word_t a);
      if (mem_model.exists(a))
      begin
         return mem_model[a];
      end
      return fill_word(a);
   endfunction

   // what a load from address a must return
   function automatic word_t expected_word(input word_t a);
      if (shadow.exists(a))
      begin
         return shadow[a];
      end
      return fill_word(a);
   endfunction

   // memory model answers one word per held request
   always @(posedge CLK)
   begin
      if (!nRST)
      begin
         mem_wait  <= 1'b1;
         wait_left <= $random(seed) & 3;
      end
      else if (mem.ren || mem.wen)
      begin
         if (!mem_wait)
         begin
            if (mem.wen)
            begin
               mem_model[mem.addr] = mem.store;   // accepted in the cycle just ended
               mem_writes++;
            end
            else
            begin
               mem_reads++;
            end
            mem_wait  <= 1'b1;
            wait_left <= $random(seed) & 3;
         end
         else if (wait_left == 0)
         begin
            mem_wait <= 1'b0;
            mem_load <= model_word(mem.addr);
         end
         else
         begin
            wait_left <= wait_left - 1;
         end
      end
      else
      begin
         mem_wait <= 1'b1;
      end
   end

   always @(posedge CLK)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: run still busy after %0d cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   `include "dcache_tb_tasks.svh"

   initial
   begin
      seed       = 29943;
      nRST       = 1'b0;
      req        = '0;
      halt       = 1'b0;
      mem_wait   = 1'b1;
      mem_load   = '0;
      mem_reads  = 0;
      mem_writes = 0;
      cycles     = 0;
      checks     = 0;
      errors     = 0;
      repeat (2) @(posedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      check_flag("rsp.dhit", rsp.dhit, 1'b0);
      check_flag("mem.ren", mem.ren, 1'b0);
      check_flag("mem.wen", mem.wen, 1'b0);
      check_flag("flushed", flushed, 1'b0);
      read_miss_then_hit();
      write_hit_then_read();
      dirty_eviction();
      lru_order();
      flush_on_halt();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- hdl/dcache.sv
`timescale 1ns/1ps

module dcache
   import dcache_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  dp_req_t  req,
   input  logic     halt,
   output dp_rsp_t  rsp,
   output logic     flushed,
   output mem_req_t mem,
   input  logic     mem_wait,
   input  word_t    mem_load
);

   idx_t              rd_idx;
   way_wr_t           wr;
   logic [N_WAYS-1:0] wr_en;
   frame_t            frames [N_WAYS];
   logic [N_WAYS-1:0] hits;
   logic              hit;
   way_t              hit_way;
   word_t             hit_word;

   dcache_ctrl u_ctrl (
      .CLK      (CLK),
      .nRST     (nRST),
      .req      (req),
      .halt     (halt),
      .rsp      (rsp),
      .flushed  (flushed),
      .mem      (mem),
      .mem_wait (mem_wait),
      .mem_load (mem_load),
      .frames   (frames),
      .hit      (hit),
      .hit_way  (hit_way),
      .hit_word (hit_word),
      .rd_idx   (rd_idx),
      .wr       (wr),
      .wr_en    (wr_en)
   );

   // all ways share the index and write bus with one enable each
   for (genvar w = 0; w < N_WAYS; w++)
   begin : g_way
      dcache_way u_way (
         .CLK     (CLK),
         .nRST    (nRST),
         .rd_idx  (rd_idx),
         .req_tag (req.addr.tag),
         .wr_en   (wr_en[w]),
         .wr      (wr),
         .frame   (frames[w]),
         .hit     (hits[w])
      );
   end

   dcache_hit_sel u_hit_sel (
      .req_addr (req.addr),
      .frames   (frames),
      .hits     (hits),
      .hit      (hit),
      .hit_way  (hit_way),
      .hit_word (hit_word)
   );

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic              CLK,
   input  logic              nRST,
   input  dp_req_t           req,
   input  logic              halt,
   output dp_rsp_t           rsp,
   output logic              flushed,
   output mem_req_t          mem,
   input  logic              mem_wait,
   input  word_t             mem_load,
   input  frame_t            frames [N_WAYS],
   input  logic              hit,
   input  way_t              hit_way,
   input  word_t             hit_word,
   output idx_t              rd_idx,
   output way_wr_t           wr,
   output logic [N_WAYS-1:0] wr_en
);

   typedef enum logic [2:0] {IDLE, WB0, WB1, FILL0, FILL1, FLUSH, DONE} state_t;

   state_t            state, next_state;
   logic [N_SETS-1:0] lru;        // way to replace next in each set
   logic              lru_upd;
   way_t              lru_way;    // way just used
   way_t              victim;
   frame_t            vframe;
   frame_t            fframe;
   logic [BLK_W-1:0]  blk_sel;    // word moved in this memory beat
   logic              access;
   logic              wr_go;
   way_t              wr_way;
   idx_t              flush_idx, flush_idx_n;
   way_t              flush_way, flush_way_n;
   logic [BLK_W-1:0]  flush_blk, flush_blk_n;
   logic              flush_step;

   assign access  = req.ren | req.wen;
   assign victim  = way_t'(lru[req.addr.idx]);
   assign vframe  = frames[victim];
   assign fframe  = frames[flush_way];
   assign rd_idx  = (state == FLUSH) ? flush_idx : req.addr.idx;
   assign flushed = (state == DONE);
   assign wr_en   = wr_go ? (N_WAYS'(1) << wr_way) : '0;

   // requested word first and the other word second
   assign blk_sel = (state == WB1 || state == FILL1) ? ~req.addr.blk : req.addr.blk;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         lru       <= '0;
         flush_idx <= '0;
         flush_way <= '0;
         flush_blk <= '0;
      end
      else
      begin
         state     <= next_state;
         flush_idx <= flush_idx_n;
         flush_way <= flush_way_n;
         flush_blk <= flush_blk_n;
         if (lru_upd)
         begin
            lru[req.addr.idx] <= ~lru_way;   // point at the other way
         end
      end
   end

   always_comb
   begin
      next_state  = state;
      rsp         = '0;
      mem         = '0;
      wr          = '0;
      wr.idx      = req.addr.idx;
      wr.tag      = req.addr.tag;
      wr.valid    = 1'b1;
      wr_go       = 1'b0;
      wr_way      = victim;
      lru_upd     = 1'b0;
      lru_way     = victim;
      flush_idx_n = flush_idx;
      flush_way_n = flush_way;
      flush_blk_n = flush_blk;
      flush_step  = 1'b0;

      case (state)
         IDLE:
         begin
            if (halt)
            begin
               next_state = FLUSH;
            end
            else if (access && hit)
            begin
               rsp.dhit = 1'b1;
               rsp.load = hit_word;
               lru_upd  = 1'b1;
               lru_way  = hit_way;
               if (req.wen)
               begin
                  wr_go                 = 1'b1;
                  wr_way                = hit_way;
                  wr.dirty              = 1'b1;
                  wr.mask[req.addr.blk] = 1'b1;
                  wr.words              = {2{req.store}};
               end
            end
            else if (access)
            begin
               next_state = (vframe.valid && vframe.dirty) ? WB0 : FILL0;
            end
         end

         WB0, WB1:
         begin
            mem.wen   = 1'b1;
            mem.addr  = {vframe.tag, req.addr.idx, blk_sel, {BYTE_W{1'b0}}};
            mem.store = vframe.words[blk_sel];
            if (!mem_wait)
            begin
               next_state = (state == WB0) ? WB1 : FILL0;
            end
         end

         FILL0:
         begin
            mem.ren  = 1'b1;
            mem.addr = {req.addr.tag, req.addr.idx, blk_sel, {BYTE_W{1'b0}}};
            if (!mem_wait)
            begin
               wr_go              = 1'b1;
               wr.mask[blk_sel]   = 1'b1;   // frame now valid and clean
               wr.words[blk_sel]  = mem_load;
               next_state         = FILL1;
            end
         end

         FILL1:
         begin
            mem.ren  = 1'b1;
            mem.addr = {req.addr.tag, req.addr.idx, blk_sel, {BYTE_W{1'b0}}};
            if (!mem_wait)
            begin
               rsp.dhit          = 1'b1;
               rsp.load          = vframe.words[req.addr.blk];   // stored in FILL0
               wr_go             = 1'b1;
               wr.dirty          = req.wen;
               wr.mask[blk_sel]  = 1'b1;
               wr.words[blk_sel] = mem_load;
               if (req.wen)
               begin
                  wr.mask[req.addr.blk]  = 1'b1;   // merge the store
                  wr.words[req.addr.blk] = req.store;
               end
               lru_upd    = 1'b1;
               next_state = IDLE;
            end
         end

         FLUSH:
         begin
            if (fframe.valid && fframe.dirty)
            begin
               mem.wen   = 1'b1;
               mem.addr  = {fframe.tag, flush_idx, flush_blk, {BYTE_W{1'b0}}};
               mem.store = fframe.words[flush_blk];
               if (!mem_wait)
               begin
                  flush_blk_n = flush_blk + 1'b1;
                  flush_step  = &flush_blk;   // last word of block
               end
            end
            else
            begin
               flush_step = 1'b1;   // clean or empty frame is skipped
            end

            if (flush_step)
            begin
               if (flush_idx == idx_t'(N_SETS - 1))
               begin
                  flush_idx_n = '0;
                  if (flush_way == way_t'(N_WAYS - 1))
                  begin
                     next_state = DONE;
                  end
                  else
                  begin
                     flush_way_n = flush_way + 1'b1;
                  end
               end
               else
               begin
                  flush_idx_n = flush_idx + 1'b1;
               end
            end
         end

         DONE:
         begin
            // parked until reset
         end

         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   a_no_rw: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem.ren && mem.wen))
      else $error("dcache_ctrl: ren and wen both high");

   // a stalled memory request keeps its address and data
   a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
      (mem.ren || mem.wen) && mem_wait |=> $stable(mem))
      else $error("dcache_ctrl: memory request changed while mem_wait high");

endmodule

//--- hdl/dcache_hit_sel.sv
`timescale 1ns/1ps

module dcache_hit_sel
   import dcache_pkg::*;
(
   input  addr_t             req_addr,
   input  frame_t            frames [N_WAYS],
   input  logic [N_WAYS-1:0] hits,
   output logic              hit,
   output way_t              hit_way,
   output word_t             hit_word
);

   assign hit = |hits;

   // lowest hitting way wins
   always_comb
   begin
      hit_way = '0;
      for (int w = N_WAYS - 1; w >= 0; w--)
      begin
         if (hits[w])
         begin
            hit_way = way_t'(w);
         end
      end
   end

   // word within the block
   assign hit_word = frames[hit_way].words[req_addr.blk];

   // a tag may live in only one way of a set
   always_comb
   begin
      if (!$isunknown(hits))
      begin
         a_one_hit: assert final ($onehot0(hits))
            else $error("dcache_hit_sel: more than one way hit, hits=%h", hits);
      end
   end

endmodule

//--- hdl/dcache_pkg.sv
package dcache_pkg;

   // geometry
   localparam int WORD_W = 32;
   localparam int N_WAYS = 2;
   localparam int N_SETS = 8;
   localparam int IDX_W  = 3;
   localparam int BLK_W  = 1;   // two words per block
   localparam int BYTE_W = 2;
   localparam int TAG_W  = WORD_W - IDX_W - BLK_W - BYTE_W;

   typedef logic [WORD_W-1:0]         word_t;
   typedef logic [TAG_W-1:0]          tag_t;
   typedef logic [IDX_W-1:0]          idx_t;
   typedef logic [$clog2(N_WAYS)-1:0] way_t;

   // byte address as seen by the cache
   typedef struct packed {
      tag_t             tag;
      idx_t             idx;
      logic [BLK_W-1:0] blk;
      logic [BYTE_W-1:0] byte_off;
   } addr_t;

   typedef struct packed {
      logic        valid;
      logic        dirty;
      tag_t        tag;
      word_t [1:0] words;   // indexed by block offset
   } frame_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      addr_t addr;
      word_t store;
   } dp_req_t;

   typedef struct packed {
      logic  dhit;
      word_t load;
   } dp_rsp_t;

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t store;
   } mem_req_t;

   // one frame update for the way picked by wr_en
   typedef struct packed {
      idx_t        idx;
      tag_t        tag;
      logic        valid;
      logic        dirty;
      logic [1:0]  mask;    // which words get written
      word_t [1:0] words;
   } way_wr_t;

endpackage

//--- hdl/dcache_way.sv
`timescale 1ns/1ps

module dcache_way
   import dcache_pkg::*;
(
   input  logic    CLK,
   input  logic    nRST,
   input  idx_t    rd_idx,
   input  tag_t    req_tag,
   input  logic    wr_en,
   input  way_wr_t wr,
   output frame_t  frame,
   output logic    hit
);

   // per-set flags and frame storage
   logic [N_SETS-1:0] valid_q;
   logic [N_SETS-1:0] dirty_q;
   tag_t              tag_mem [N_SETS];
   word_t [1:0]       data_mem [N_SETS];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else if (wr_en)
      begin
         valid_q[wr.idx] <= wr.valid;
         dirty_q[wr.idx] <= wr.dirty;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         tag_mem[wr.idx] <= wr.tag;
         for (int b = 0; b < 2; b++)
         begin
            if (wr.mask[b])
            begin
               data_mem[wr.idx][b] <= wr.words[b];   // masked word write
            end
         end
      end
   end

   // read side is asynchronous
   always_comb
   begin
      frame.valid = valid_q[rd_idx];
      frame.dirty = dirty_q[rd_idx];
      frame.tag   = tag_mem[rd_idx];
      frame.words = data_mem[rd_idx];
   end

   assign hit = frame.valid && (frame.tag == req_tag);

   // controller must never write a frame it cannot name
   a_wr_idx_known: assert property (@(posedge CLK) disable iff (!nRST)
      wr_en |-> !$isunknown(wr.idx))
      else $error("dcache_way: write with unknown index");

endmodule

//--- verilog.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_way.sv
hdl/dcache_hit_sel.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
dv/dcache_tb.sv
